//--- design/dma_types_pkg.sv
/*
 DMA command types: opcode and engine state enums,
 the queued command struct and the address step
*/

`default_nettype none

package dma_types_pkg;

	typedef enum logic [1:0] {
		NOP  = 2'd0, // Retires without bus traffic
		FILL = 2'd1,
		COPY = 2'd2,
		FEED = 2'd3
	} dma_op_t;

	typedef enum logic [2:0] {
		IDLE,
		FETCH,   // Queue pop in flight
		DECODE,  // Popped command valid
		RD_REQ,
		RD_WAIT,
		WR_REQ,
		WR_WAIT,
		GAP      // Bus released for one cycle
	} engine_state_t;

	typedef struct packed {
		dma_op_t     op;
		logic [31:0] src_or_value; // Source address, or fill value
		logic [31:0] dst;
		logic [31:0] count;        // Words moved minus one
		logic [31:0] tag;
	} dma_cmd_t;

	localparam logic [31:0] ADDR_STEP = 32'd4;

endpackage

`default_nettype wire

//--- design/dma_bus_pkg.sv
/*
 Bus master request struct, CPU register map and status bits
*/

`default_nettype none

package dma_bus_pkg;

	typedef struct packed {
		logic        rw;      // 1 is write
		logic [31:0] address;
		logic [31:0] wdata;
	} bus_req_t;

	// Write side
	localparam logic [1:0] REG_SRC   = 2'd0;
	localparam logic [1:0] REG_DST   = 2'd1;
	localparam logic [1:0] REG_COUNT = 2'd2;
	localparam logic [1:0] REG_CTRL  = 2'd3;

	// Read aliases
	localparam logic [1:0] REG_QUEUED  = 2'd0;
	localparam logic [1:0] REG_RETIRED = 2'd1;

	localparam int STATUS_BUSY = 0;
	localparam int STATUS_FULL = 1;

endpackage

`default_nettype wire

//--- design/cmd_fifo.sv
/*
 Command queue, circular buffer with wrap bit and registered read data
*/

`timescale 1ns/1ps
`default_nettype none

module cmd_fifo #(
	parameter int DEPTH = 8
) (
	input  logic                    i_clock,
	input  logic                    i_arst_n,
	input  logic                    i_push,
	input  dma_types_pkg::dma_cmd_t i_push_data,
	input  logic                    i_pop,
	output dma_types_pkg::dma_cmd_t o_pop_data,
	output logic                    o_empty,
	output logic                    o_full
);
	localparam int AW = $clog2(DEPTH);

	dma_types_pkg::dma_cmd_t mem [DEPTH];
	logic [AW:0] wr_ptr;
	logic [AW:0] rd_ptr;
	logic        do_push;
	logic        do_pop;

	assign o_empty = (wr_ptr == rd_ptr);
	// Same slot, opposite lap
	assign o_full = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

	assign do_push = i_push && !o_full;
	assign do_pop  = i_pop && !o_empty;

	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	always_ff @(posedge i_clock) begin
		if (do_push)
			mem[wr_ptr[AW-1:0]] <= i_push_data;
		if (do_pop)
			o_pop_data <= mem[rd_ptr[AW-1:0]]; // Valid the cycle after the pop
	end

endmodule

`default_nettype wire

//--- design/dma_regs.sv
/*
 CPU register file: pending command fields, launch into the queue,
 queued and retired counters, status word
*/

`timescale 1ns/1ps
`default_nettype none

module dma_regs (
	input  logic                    i_clock,
	input  logic                    i_arst_n,
	input  logic                    i_request,
	input  logic                    i_rw,
	input  logic [1:0]              i_address,
	input  logic [31:0]             i_wdata,
	output logic [31:0]             o_rdata,
	output logic                    o_ready,
	output logic                    o_push,
	output dma_types_pkg::dma_cmd_t o_push_cmd,
	input  logic                    i_queue_full,
	input  logic                    i_retire,
	input  logic [31:0]             i_retire_tag,
	input  logic                    i_busy
);
	logic [31:0] queued_q;
	logic [31:0] retired_q;
	logic [31:0] status;
	logic        access;
	logic        launch;
	logic        launch_ok;

	assign access    = i_request && !o_ready; // New access not yet answered
	assign launch    = access && i_rw && (i_address == dma_bus_pkg::REG_CTRL);
	assign launch_ok = launch && !i_queue_full;

	always_comb begin
		status = '0;
		status[dma_bus_pkg::STATUS_BUSY] = i_busy;
		status[dma_bus_pkg::STATUS_FULL] = i_queue_full;
	end

	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_ready   <= 1'b0;
			o_push    <= 1'b0;
			queued_q  <= '0;
			retired_q <= '0;
		end else begin
			o_push <= launch_ok; // Queue sees the command built on this edge
			if (launch_ok)
				queued_q <= queued_q + 32'd1;
			if (i_retire)
				retired_q <= i_retire_tag;
			// A launch into a full queue waits here until a slot frees
			if (launch_ok || (access && !launch))
				o_ready <= 1'b1;
			else if (!i_request)
				o_ready <= 1'b0;
		end
	end

	always_ff @(posedge i_clock) begin
		if (access && !i_rw) begin
			case (i_address)
				dma_bus_pkg::REG_QUEUED:  o_rdata <= queued_q;
				dma_bus_pkg::REG_RETIRED: o_rdata <= retired_q;
				dma_bus_pkg::REG_CTRL:    o_rdata <= status;
				default:                  o_rdata <= '0;
			endcase
		end
		if (access && i_rw) begin
			case (i_address)
				dma_bus_pkg::REG_SRC:   o_push_cmd.src_or_value <= i_wdata;
				dma_bus_pkg::REG_DST:   o_push_cmd.dst <= i_wdata;
				dma_bus_pkg::REG_COUNT: o_push_cmd.count <= i_wdata;
				default: begin
					if (!i_queue_full) begin
						o_push_cmd.op  <= dma_types_pkg::dma_op_t'(i_wdata[1:0]);
						o_push_cmd.tag <= queued_q + 32'd1;
					end
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- design/dma_walker.sv
/*
 Working addresses and remaining word count of the active command
*/

`timescale 1ns/1ps
`default_nettype none

module dma_walker (
	input  logic                    i_clock,
	input  logic                    i_arst_n,
	input  logic                    i_load,
	input  dma_types_pkg::dma_cmd_t i_cmd,
	input  logic                    i_step_src,
	input  logic                    i_step_dst,
	input  logic                    i_count_dec,
	output logic [31:0]             o_src,
	output logic [31:0]             o_dst,
	output logic [31:0]             o_value,
	output logic                    o_last
);
	logic [31:0] src_q;
	logic [31:0] dst_q;
	logic [31:0] remain_q;

	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			src_q    <= '0;
			dst_q    <= '0;
			remain_q <= '0;
		end else if (i_load) begin
			src_q    <= i_cmd.src_or_value;
			dst_q    <= i_cmd.dst;
			remain_q <= i_cmd.count;
		end else begin
			if (i_step_src)
				src_q <= src_q + dma_types_pkg::ADDR_STEP;
			if (i_step_dst)
				dst_q <= dst_q + dma_types_pkg::ADDR_STEP;
			if (i_count_dec)
				remain_q <= remain_q - 32'd1;
		end
	end

	assign o_src   = src_q;
	assign o_dst   = dst_q;
	// FILL never steps the source, so the register keeps the fill value
	assign o_value = src_q;
	assign o_last  = (remain_q == '0);

endmodule

`default_nettype wire

//--- design/dma_engine.sv
/*
 Bus master FSM: fetches commands and sequences reads, writes and gaps
*/

`timescale 1ns/1ps
`default_nettype none

module dma_engine (
	input  logic                    i_clock,
	input  logic                    i_arst_n,
	input  logic                    i_queue_empty,
	output logic                    o_pop,
	input  dma_types_pkg::dma_cmd_t i_cmd,
	output logic                    o_load,
	output logic                    o_step_src,
	output logic                    o_step_dst,
	output logic                    o_count_dec,
	input  logic [31:0]             i_src,
	input  logic [31:0]             i_dst,
	input  logic [31:0]             i_value,
	input  logic                    i_last,
	output logic                    o_bus_request,
	output dma_bus_pkg::bus_req_t   o_bus_req,
	input  logic                    i_bus_ready,
	input  logic [31:0]             i_bus_rdata,
	output logic                    o_retire,
	output logic [31:0]             o_retire_tag,
	output logic                    o_busy
);
	dma_types_pkg::engine_state_t state_q;
	dma_types_pkg::engine_state_t state_d;
	dma_types_pkg::dma_op_t       op_q;
	logic [31:0]                  tag_q;
	logic [31:0]                  data_q; // Read word held for the write
	logic                         accept;
	logic                         retire_now;

	assign accept = o_bus_request && i_bus_ready;

	always_comb begin
		state_d     = state_q;
		o_pop       = 1'b0;
		o_load      = 1'b0;
		o_step_src  = 1'b0;
		o_step_dst  = 1'b0;
		o_count_dec = 1'b0;
		retire_now  = 1'b0;
		case (state_q)
			dma_types_pkg::IDLE:
				if (!i_queue_empty)
					state_d = dma_types_pkg::FETCH;
			dma_types_pkg::FETCH: begin
				o_pop   = 1'b1;
				state_d = dma_types_pkg::DECODE;
			end
			dma_types_pkg::DECODE: begin
				o_load = 1'b1;
				case (i_cmd.op)
					dma_types_pkg::NOP: begin
						retire_now = 1'b1;
						state_d    = dma_types_pkg::IDLE;
					end
					dma_types_pkg::FILL: state_d = dma_types_pkg::WR_REQ;
					default:             state_d = dma_types_pkg::RD_REQ;
				endcase
			end
			dma_types_pkg::RD_REQ:  state_d = dma_types_pkg::RD_WAIT;
			dma_types_pkg::RD_WAIT:
				if (accept) begin
					o_step_src = 1'b1;
					state_d    = dma_types_pkg::WR_REQ;
				end
			dma_types_pkg::WR_REQ:  state_d = dma_types_pkg::WR_WAIT;
			dma_types_pkg::WR_WAIT:
				if (accept) begin
					o_step_dst = (op_q != dma_types_pkg::FEED); // Port address is fixed
					if (i_last) begin
						retire_now = 1'b1;
						state_d    = dma_types_pkg::IDLE;
					end else begin
						o_count_dec = 1'b1;
						state_d     = dma_types_pkg::GAP;
					end
				end
			dma_types_pkg::GAP:
				state_d = (op_q == dma_types_pkg::FILL) ? dma_types_pkg::WR_REQ
				                                        : dma_types_pkg::RD_REQ;
			default: state_d = dma_types_pkg::IDLE;
		endcase
	end

	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			state_q       <= dma_types_pkg::IDLE;
			o_bus_request <= 1'b0;
			o_retire      <= 1'b0;
		end else begin
			state_q  <= state_d;
			o_retire <= retire_now;
			if (state_q == dma_types_pkg::RD_REQ || state_q == dma_types_pkg::WR_REQ)
				o_bus_request <= 1'b1;
			else if (accept)
				o_bus_request <= 1'b0; // Drop right after acceptance
		end
	end

	always_ff @(posedge i_clock) begin
		if (o_load) begin
			op_q  <= i_cmd.op;
			tag_q <= i_cmd.tag;
		end
		if (state_q == dma_types_pkg::RD_WAIT && accept)
			data_q <= i_bus_rdata;
		if (state_q == dma_types_pkg::RD_REQ) begin
			o_bus_req.rw      <= 1'b0;
			o_bus_req.address <= i_src;
			o_bus_req.wdata   <= '0;
		end else if (state_q == dma_types_pkg::WR_REQ) begin
			o_bus_req.rw      <= 1'b1;
			o_bus_req.address <= i_dst;
			o_bus_req.wdata   <= (op_q == dma_types_pkg::FILL) ? i_value : data_q;
		end
	end

	assign o_retire_tag = tag_q;
	assign o_busy       = (state_q != dma_types_pkg::IDLE) || !i_queue_empty;

endmodule

`default_nettype wire

//--- design/dma_top.sv
/*
 DMA controller top: register file, command queue, engine and walker
*/

`timescale 1ns/1ps
`default_nettype none

module dma_top #(
	parameter int QUEUE_DEPTH = 8
) (
	input  logic                  i_clock,
	input  logic                  i_arst_n,
	input  logic                  i_request,
	input  logic                  i_rw,
	input  logic [1:0]            i_address,
	input  logic [31:0]           i_wdata,
	output logic [31:0]           o_rdata,
	output logic                  o_ready,
	output logic                  o_bus_request,
	output dma_bus_pkg::bus_req_t o_bus_req,
	input  logic                  i_bus_ready,
	input  logic [31:0]           i_bus_rdata
);
	dma_types_pkg::dma_cmd_t push_cmd;
	dma_types_pkg::dma_cmd_t pop_cmd;
	logic        push, pop, q_empty, q_full;
	logic        retire, busy;
	logic [31:0] retire_tag;
	logic        load, step_src, step_dst, count_dec, last;
	logic [31:0] src, dst, value;

	dma_regs u_regs (
		.i_clock(i_clock), .i_arst_n(i_arst_n),
		.i_request(i_request), .i_rw(i_rw), .i_address(i_address), .i_wdata(i_wdata),
		.o_rdata(o_rdata), .o_ready(o_ready),
		.o_push(push), .o_push_cmd(push_cmd), .i_queue_full(q_full),
		.i_retire(retire), .i_retire_tag(retire_tag), .i_busy(busy)
	);

	cmd_fifo #(.DEPTH(QUEUE_DEPTH)) u_queue (
		.i_clock(i_clock), .i_arst_n(i_arst_n),
		.i_push(push), .i_push_data(push_cmd),
		.i_pop(pop), .o_pop_data(pop_cmd),
		.o_empty(q_empty), .o_full(q_full)
	);

	dma_engine u_engine (
		.i_clock(i_clock), .i_arst_n(i_arst_n),
		.i_queue_empty(q_empty), .o_pop(pop), .i_cmd(pop_cmd),
		.o_load(load), .o_step_src(step_src), .o_step_dst(step_dst),
		.o_count_dec(count_dec), .i_src(src), .i_dst(dst), .i_value(value), .i_last(last),
		.o_bus_request(o_bus_request), .o_bus_req(o_bus_req),
		.i_bus_ready(i_bus_ready), .i_bus_rdata(i_bus_rdata),
		.o_retire(retire), .o_retire_tag(retire_tag), .o_busy(busy)
	);

	dma_walker u_walker (
		.i_clock(i_clock), .i_arst_n(i_arst_n),
		.i_load(load), .i_cmd(pop_cmd),
		.i_step_src(step_src), .i_step_dst(step_dst), .i_count_dec(count_dec),
		.o_src(src), .o_dst(dst), .o_value(value), .o_last(last)
	);

endmodule

`default_nettype wire

//--- sim/dma_checker.sv
/*
 Protocol assertions on the DMA CPU and bus ports, bound into dma_top
*/

`timescale 1ns/1ps
`default_nettype none

module dma_checker (
	input logic                  i_clock,
	input logic                  i_arst_n,
	input logic                  i_request,
	input logic                  i_ready,
	input logic                  i_bus_request,
	input dma_bus_pkg::bus_req_t i_bus_req,
	input logic                  i_bus_ready
);
	// Both handshakes come out of reset idle
	a_reset_idle: assert property (@(posedge i_clock)
		$rose(i_arst_n) |-> !i_ready && !i_bus_request)
		else $error("ready or bus request high when reset was released");

	a_req_stable: assert property (@(posedge i_clock) disable iff (!i_arst_n)
		i_bus_request && !i_bus_ready |=> i_bus_request && $stable(i_bus_req))
		else $error("bus request changed before it was accepted");

	a_req_gap: assert property (@(posedge i_clock) disable iff (!i_arst_n)
		i_bus_request && i_bus_ready |=> !i_bus_request)
		else $error("bus request not dropped after acceptance");

	a_ready_held: assert property (@(posedge i_clock) disable iff (!i_arst_n)
		i_ready && i_request |=> i_ready)
		else $error("CPU ready fell while the request was still held");

endmodule

bind dma_top dma_checker u_checker (
	.i_clock(i_clock),
	.i_arst_n(i_arst_n),
	.i_request(i_request),
	.i_ready(o_ready),
	.i_bus_request(o_bus_request),
	.i_bus_req(o_bus_req),
	.i_bus_ready(i_bus_ready)
);

`default_nettype wire

//--- sim/tb_dma.sv
/*
 DMA controller testbench with a bus memory model, a command table
 with its reference model, register and memory checks and a watchdog
*/

`timescale 1ns/1ps
`default_nettype none

module tb_dma;
	localparam int QUEUE_DEPTH = 4;
	localparam int ROWS = 10;
	localparam int SOLO_ROWS = 4;   // Rows run one at a time
	localparam int MAX_WORDS = 6;
	localparam int RESET_CYCLES = 10;
	localparam int HOLD_CYCLES = 16;
	localparam int MEM_WORDS = 1024;
	localparam int WATCHDOG_CYCLES = ROWS * MAX_WORDS * 20 + RESET_CYCLES;
	localparam logic [31:0] FEED_PORT = 32'h0000_0F00;
	localparam logic [31:0] SEED = 32'hf20fd3e7;

	logic                  i_clock;
	logic                  i_arst_n;
	logic                  i_request;
	logic                  i_rw;
	logic [1:0]            i_address;
	logic [31:0]           i_wdata;
	logic [31:0]           o_rdata;
	logic                  o_ready;
	logic                  o_bus_request;
	dma_bus_pkg::bus_req_t o_bus_req;
	logic                  i_bus_ready;
	logic [31:0]           i_bus_rdata;

	logic [31:0] mem [MEM_WORDS];
	logic [31:0] model_mem [MEM_WORDS]; // Expected memory image
	logic [31:0] feed_log [$];
	logic [31:0] expected_feed [$];
	dma_types_pkg::dma_cmd_t table_rows [ROWS];
	logic [31:0] rng;
	logic [1:0]  wait_left;           // Slave wait states still due
	logic        stall;
	int unsigned bus_writes;
	int          value_errors;
	int          other_errors;

	dma_top #(.QUEUE_DEPTH(QUEUE_DEPTH)) i_dut (
		.i_clock(i_clock), .i_arst_n(i_arst_n),
		.i_request(i_request), .i_rw(i_rw), .i_address(i_address), .i_wdata(i_wdata),
		.o_rdata(o_rdata), .o_ready(o_ready),
		.o_bus_request(o_bus_request), .o_bus_req(o_bus_req),
		.i_bus_ready(i_bus_ready), .i_bus_rdata(i_bus_rdata)
	);

	always begin
		i_clock = 1'b0;
		#2;
		i_clock = 1'b1;
		#2;
	end

	function automatic logic [31:0] next_random(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] mem_pattern(input logic [31:0] index);
		return 32'hC0DE_0000 ^ (index * 32'h9E37_79B1);
	endfunction

	// Word memory on the bus with 0 to 3 wait states per access
	always @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			i_bus_ready <= 1'b0;
			i_bus_rdata <= '0;
			wait_left   <= 2'd0;
			rng         <= SEED;
			bus_writes  <= 0;
			for (int i = 0; i < MEM_WORDS; i++)
				mem[i] <= mem_pattern(i);
		end else begin
			i_bus_ready <= 1'b0;
			if (o_bus_request && !i_bus_ready) begin
				if (wait_left != 2'd0)
					wait_left <= wait_left - 2'd1;
				else if (!stall) begin
					i_bus_ready <= 1'b1;
					rng         <= next_random(rng);
					wait_left   <= rng[1:0];
					if (o_bus_req.rw) begin
						mem[o_bus_req.address[11:2]] <= o_bus_req.wdata;
						bus_writes <= bus_writes + 1;
						if (o_bus_req.address == FEED_PORT)
							feed_log.push_back(o_bus_req.wdata);
					end else
						i_bus_rdata <= mem[o_bus_req.address[11:2]];
				end
			end
		end
	end

	task automatic build_table();
		table_rows[0] = '{dma_types_pkg::FILL, 32'hA5A5_0001, 32'h0000_0100, 32'd5, 32'd1};
		table_rows[1] = '{dma_types_pkg::COPY, 32'h0000_0200, 32'h0000_0300, 32'd3, 32'd2};
		table_rows[2] = '{dma_types_pkg::FEED, 32'h0000_0400, FEED_PORT, 32'd2, 32'd3};
		table_rows[3] = '{dma_types_pkg::NOP, 32'h0, 32'h0, 32'd0, 32'd4};
		table_rows[4] = '{dma_types_pkg::COPY, 32'h0000_0100, 32'h0000_0500, 32'd5, 32'd5};
		table_rows[5] = '{dma_types_pkg::FILL, 32'h1234_5678, 32'h0000_0600, 32'd1, 32'd6};
		table_rows[6] = '{dma_types_pkg::COPY, 32'h0000_0300, 32'h0000_0700, 32'd3, 32'd7};
		table_rows[7] = '{dma_types_pkg::FEED, 32'h0000_0200, FEED_PORT, 32'd1, 32'd8};
		table_rows[8] = '{dma_types_pkg::NOP, 32'h0, 32'h0, 32'd0, 32'd9};
		table_rows[9] = '{dma_types_pkg::FILL, 32'h0BAD_F00D, 32'h0000_0800, 32'd2, 32'd10};
	endtask

	task automatic init_inputs();
		i_arst_n  <= 1'b1;
		i_request <= 1'b0;
		i_rw      <= 1'b0;
		i_address <= '0;
		i_wdata   <= '0;
		stall     <= 1'b0;
	endtask

	task automatic apply_reset();
		#1;
		i_arst_n <= 1'b0;
		repeat (RESET_CYCLES) @(posedge i_clock);
		i_arst_n <= 1'b1;
	endtask

	task automatic set_stall(input logic level);
		@(posedge i_clock);
		stall <= level;
	endtask

	task automatic start_access(input logic rw, input logic [1:0] addr, input logic [31:0] data);
		@(posedge i_clock);
		i_request <= 1'b1;
		i_rw      <= rw;
		i_address <= addr;
		i_wdata   <= data;
	endtask

	// Ends the four-phase handshake once ready has risen and fallen again
	task automatic finish_access(output logic [31:0] rdata);
		do @(posedge i_clock); while (!o_ready);
		rdata = o_rdata;
		i_request <= 1'b0;
		do @(posedge i_clock); while (o_ready);
	endtask

	task automatic write_reg(input logic [1:0] addr, input logic [31:0] data);
		logic [31:0] unused;
		start_access(1'b1, addr, data);
		finish_access(unused);
	endtask

	task automatic read_reg(input logic [1:0] addr, output logic [31:0] data);
		start_access(1'b0, addr, 32'h0);
		finish_access(data);
	endtask

	task automatic load_fields(input dma_types_pkg::dma_cmd_t row);
		write_reg(dma_bus_pkg::REG_SRC, row.src_or_value);
		write_reg(dma_bus_pkg::REG_DST, row.dst);
		write_reg(dma_bus_pkg::REG_COUNT, row.count);
	endtask

	task automatic launch_row(input dma_types_pkg::dma_cmd_t row);
		load_fields(row);
		write_reg(dma_bus_pkg::REG_CTRL, {30'd0, row.op});
	endtask

	// N+1 words per command and a 4 byte address step
	task automatic apply_to_model(input dma_types_pkg::dma_cmd_t c);
		logic [31:0] src;
		logic [31:0] dst;
		logic [31:0] word;
		src = c.src_or_value;
		dst = c.dst;
		if (c.op != dma_types_pkg::NOP) begin
			for (int unsigned n = 0; n <= c.count; n++) begin
				word = (c.op == dma_types_pkg::FILL) ? c.src_or_value : model_mem[src[11:2]];
				model_mem[dst[11:2]] = word;
				src = src + 32'd4;
				if (c.op == dma_types_pkg::FEED)
					expected_feed.push_back(word); // Port address stays put
				else
					dst = dst + 32'd4;
			end
		end
	endtask

	// Polls status until the queue is empty and the engine is idle
	task automatic wait_idle();
		logic [31:0] rd;
		read_reg(dma_bus_pkg::REG_CTRL, rd);
		while (rd[dma_bus_pkg::STATUS_BUSY])
			read_reg(dma_bus_pkg::REG_CTRL, rd);
	endtask

	task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			value_errors++;
			$display("CHECK FAILED %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_status(input logic [31:0] status, input logic busy, input logic full);
		logic [1:0] got;
		got = {status[dma_bus_pkg::STATUS_FULL], status[dma_bus_pkg::STATUS_BUSY]};
		if (got !== {full, busy}) begin
			value_errors++;
			$display("CHECK FAILED status{full,busy} got %h expected %h", got, {full, busy});
		end
	endtask

	task automatic check_tag(input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			value_errors++;
			$display("CHECK FAILED retired_tag got %h expected %h", got, exp);
		end
	endtask

	task automatic compare_memory();
		for (int i = 0; i < MEM_WORDS; i++)
			check_word($sformatf("mem[0x%03h]", i * 4), mem[i], model_mem[i]);
	endtask

	task automatic compare_feed();
		check_word("feed_writes", feed_log.size(), expected_feed.size());
		for (int i = 0; i < feed_log.size() && i < expected_feed.size(); i++)
			check_word($sformatf("feed_log[%0d]", i), feed_log[i], expected_feed[i]);
	endtask

	initial begin
		logic [31:0] rd;
		int unsigned writes_before;
		value_errors = 0;
		other_errors = 0;
		init_inputs();
		build_table();
		for (int i = 0; i < MEM_WORDS; i++)
			model_mem[i] = mem_pattern(i);
		apply_reset();

		// FILL, COPY, FEED and NOP each run to retirement
		for (int i = 0; i < SOLO_ROWS; i++) begin
			writes_before = bus_writes;
			launch_row(table_rows[i]);
			apply_to_model(table_rows[i]);
			wait_idle();
			read_reg(dma_bus_pkg::REG_RETIRED, rd);
			check_tag(rd, table_rows[i].tag);
			if (table_rows[i].op == dma_types_pkg::NOP)
				check_word("bus_writes", bus_writes, writes_before);
			compare_memory();
		end
		compare_feed();

		// Slave stalled with one command in flight and the queue filled behind it
		set_stall(1'b1);
		launch_row(table_rows[SOLO_ROWS]);
		apply_to_model(table_rows[SOLO_ROWS]);
		do @(posedge i_clock); while (!o_bus_request);
		for (int i = SOLO_ROWS + 1; i < ROWS - 1; i++) begin
			launch_row(table_rows[i]);
			apply_to_model(table_rows[i]);
		end
		read_reg(dma_bus_pkg::REG_CTRL, rd);
		check_status(rd, 1'b1, 1'b1);

		load_fields(table_rows[ROWS-1]);
		start_access(1'b1, dma_bus_pkg::REG_CTRL, {30'd0, table_rows[ROWS-1].op});
		repeat (HOLD_CYCLES) begin
			@(posedge i_clock);
			if (o_ready) begin
				other_errors++;
				$display("Launch into the full queue was answered while the bus was stalled");
			end
		end
		set_stall(1'b0);
		finish_access(rd);
		apply_to_model(table_rows[ROWS-1]);
		read_reg(dma_bus_pkg::REG_RETIRED, rd);
		if (rd < table_rows[SOLO_ROWS].tag) begin
			other_errors++;
			$display("Held launch was accepted before the stalled command retired");
		end

		wait_idle();
		read_reg(dma_bus_pkg::REG_QUEUED, rd);
		check_word("queued_count", rd, ROWS);
		read_reg(dma_bus_pkg::REG_RETIRED, rd);
		check_tag(rd, ROWS);
		read_reg(dma_bus_pkg::REG_CTRL, rd);
		check_status(rd, 1'b0, 1'b0);
		compare_memory();
		compare_feed();

		$display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge i_clock);
		$display("Watchdog expired after %0d cycles, the DMA did not finish", WATCHDOG_CYCLES);
		$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog.f
design/dma_types_pkg.sv
design/dma_bus_pkg.sv
design/cmd_fifo.sv
design/dma_regs.sv
design/dma_walker.sv
design/dma_engine.sv
design/dma_top.sv
sim/dma_checker.sv
sim/tb_dma.sv

//--- run_sim.sh
#!/bin/sh
# Verilator build and run of the DMA testbench

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module tb_dma -o Vtb_dma
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/Vtb_dma > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
	echo "Simulation exited with status $run_status"
	exit 1
fi

grep -q "TEST FAILED" sim.log
grep_status=$?
if [ $grep_status -eq 0 ]; then
	exit 1
elif [ $grep_status -ne 1 ]; then
	echo "Could not search the simulation log"
	exit 1
fi
exit 0
